//--- src.f
rf_cfg_pkg.sv
wb_pkg.sv
rf_ctl_if.sv
write_back.sv
wb_log.sv
rename_table.sv
phy_regfile.sv
rf_core.sv
tb_rf_core.sv

//--- Makefile
SIM = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_rf_core
FILELIST = src.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_rf_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the renamed register-file back end
// directed rename, write-back, commit and flush cases, then
// random traffic from an LCG, all checked against a model
// of pending copies per architectural register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_rf_core import rf_cfg_pkg::*, wb_pkg::*; ();

	localparam int WAIT_LIMIT = 16;
	localparam int RANDOM_CYCLES = 3000;
	localparam arch_idx_t REG_A = 5;
	localparam arch_idx_t REG_B = 7;
	localparam arch_idx_t REG_C = 9;

	logic clk;
	logic reset;
	logic rename_req;
	arch_idx_t rename_arch;
	logic rename_grant;
	logic rename_stall;
	phys_idx_u rename_phys;
	logic [NUM_UNITS-1:0] wb_valid;
	phys_idx_u wb_phys [NUM_UNITS];
	xdata_t wb_data [NUM_UNITS];
	logic commit_req;
	arch_idx_t commit_arch;
	logic flush;
	arch_idx_t rd_arch0;
	arch_idx_t rd_arch1;
	xdata_t rd_data0;
	xdata_t rd_data1;
	logic rd_ready0;
	logic rd_ready1;

	// model of committed value and copy with pending copies oldest first
	xdata_t m_val [ARCH_REGS];
	copy_idx_t m_cptr [ARCH_REGS];
	int m_cnt [ARCH_REGS];
	xdata_t m_pval [ARCH_REGS][RP-1];
	logic m_pwr [ARCH_REGS][RP-1];

	int unsigned seed = 32'h1f63_11bd;
	string cur_test;
	int errors;
	int test_errors;
	int tests_run;
	int tests_bad;
	logic hung;
	logic seen_grant;
	logic seen_ready0;

	rf_core #(.NUM_WB (NUM_UNITS)) i_rf_core (
		.clk (clk), .reset (reset),
		.rename_req (rename_req), .rename_arch (rename_arch),
		.rename_grant (rename_grant), .rename_stall (rename_stall),
		.rename_phys (rename_phys),
		.wb_valid (wb_valid), .wb_phys (wb_phys), .wb_data (wb_data),
		.commit_req (commit_req), .commit_arch (commit_arch), .flush (flush),
		.rd_arch0 (rd_arch0), .rd_arch1 (rd_arch1),
		.rd_data0 (rd_data0), .rd_data1 (rd_data1),
		.rd_ready0 (rd_ready0), .rd_ready1 (rd_ready1)
	);

	always #4 clk = ~clk;

	function automatic int unsigned lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// upper bits are the better ones
	function automatic int rnd(input int n);
		return int'((lcg_next() >> 8) % unsigned'(n));
	endfunction

	task automatic check_data(input string what, input xdata_t exp, input xdata_t act);
		if (exp !== act) begin
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_phys(input string what, input phys_idx_u exp, input phys_idx_u act);
		if (exp !== act) begin
			$display("FAILED %s %s: expected %0d, actual %0d", cur_test, what,
				exp.flat, act.flat);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// newest copy decides value and ready
	task automatic check_read(input string what, input arch_idx_t a, input xdata_t data,
		input logic ready);
		int n;
		n = m_cnt[a];
		if (n == 0) begin
			check_flag({what, " ready"}, 1'b1, ready);
			check_data({what, " data"}, m_val[a], data);
		end else begin
			check_flag({what, " ready"}, m_pwr[a][n-1], ready);
			// unwritten copy still holds stale data
			if (m_pwr[a][n-1])
				check_data({what, " data"}, m_pval[a][n-1], data);
		end
	endtask

	task automatic drive_idle();
		rename_req = 1'b0;
		rename_arch = '0;
		wb_valid = '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			wb_phys[i] = '0;
			wb_data[i] = '0;
		end
		commit_req = 1'b0;
		commit_arch = '0;
		flush = 1'b0;
	endtask

	task automatic post_result(input wb_unit_e u, input arch_idx_t a, input int copy);
		wb_valid[u] = 1'b1;
		wb_phys[u].flat = PHYS_W'(int'(a) * RP + copy);
		wb_data[u] = {lcg_next(), lcg_next()};
	endtask

	// called just after the falling edge with inputs driven
	task automatic run_cycle();
		int r;
		int k;
		logic exp_grant;
		phys_idx_u exp_phys;
		#1;
		exp_grant = rename_req && (rename_arch != '0) && !flush
			&& (m_cnt[rename_arch] < RP - 1);
		// wrapping next copy after the newest
		exp_phys.flat = PHYS_W'(int'(rename_arch) * RP
			+ (int'(m_cptr[rename_arch]) + m_cnt[rename_arch] + 1) % RP);
		check_flag("rename_grant", exp_grant, rename_grant);
		check_flag("rename_stall", rename_req && (rename_arch != '0) && !exp_grant,
			rename_stall);
		if (exp_grant)
			check_phys("rename_phys", exp_phys, rename_phys);
		check_read("rd0", rd_arch0, rd_data0, rd_ready0);
		check_read("rd1", rd_arch1, rd_data1, rd_ready1);
		seen_grant = rename_grant;
		seen_ready0 = rd_ready0;
		@(posedge clk);
		// results land in their pending slots
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (wb_valid[i]) begin
				r = int'(wb_phys[i].f.arch);
				k = (int'(wb_phys[i].f.copy) - int'(m_cptr[r]) - 1 + RP) % RP;
				m_pval[r][k] = wb_data[i];
				m_pwr[r][k] = 1'b1;
			end
		end
		// oldest pending copy becomes the committed one
		if (commit_req) begin
			r = int'(commit_arch);
			m_val[r] = m_pval[r][0];
			for (k = 0; k < RP - 2; k++) begin
				m_pval[r][k] = m_pval[r][k+1];
				m_pwr[r][k] = m_pwr[r][k+1];
			end
			m_cnt[r]--;
			m_cptr[r] = m_cptr[r] + copy_idx_t'(1);
		end
		if (exp_grant) begin
			r = int'(rename_arch);
			m_pwr[r][m_cnt[r]] = 1'b0;
			m_cnt[r]++;
		end
		// squash back to the committed copies
		if (flush) begin
			for (r = 0; r < ARCH_REGS; r++)
				m_cnt[r] = 0;
		end
		@(negedge clk);
		drive_idle();
	endtask

	// hold the request while stalled
	task automatic wait_grant(input arch_idx_t a);
		int n;
		n = 0;
		seen_grant = 1'b0;
		while (!seen_grant && n < WAIT_LIMIT) begin
			rename_req = 1'b1;
			rename_arch = a;
			run_cycle();
			n++;
		end
		if (!seen_grant) begin
			$display("rename of x%0d was not granted within %0d cycles", a, WAIT_LIMIT);
			hung = 1'b1;
		end
	endtask

	task automatic wait_ready(input arch_idx_t a);
		int n;
		n = 0;
		seen_ready0 = 1'b0;
		while (!seen_ready0 && n < WAIT_LIMIT) begin
			rd_arch0 = a;
			run_cycle();
			n++;
		end
		if (!seen_ready0) begin
			$display("x%0d did not become ready within %0d cycles", a, WAIT_LIMIT);
			hung = 1'b1;
		end
	endtask

	task automatic drive_random();
		int r;
		int k;
		phys_idx_u cand;
		logic clash;
		rename_req = (rnd(2) == 1);
		rename_arch = arch_idx_t'(rnd(ARCH_REGS));
		// only a written oldest copy may commit
		r = 1 + rnd(ARCH_REGS - 1);
		if (m_cnt[r] > 0 && m_pwr[r][0] && rnd(2) == 1) begin
			commit_req = 1'b1;
			commit_arch = arch_idx_t'(r);
		end
		for (int i = 0; i < NUM_UNITS; i++) begin
			r = 1 + rnd(ARCH_REGS - 1);
			if (m_cnt[r] > 0) begin
				k = rnd(m_cnt[r]);
				cand.flat = PHYS_W'(r * RP + (int'(m_cptr[r]) + k + 1) % RP);
				clash = m_pwr[r][k];
				// one port per copy and cycle
				for (int j = 0; j < i; j++) begin
					if (wb_valid[j] && wb_phys[j] == cand)
						clash = 1'b1;
				end
				if (!clash) begin
					wb_valid[i] = 1'b1;
					wb_phys[i] = cand;
					wb_data[i] = {lcg_next(), lcg_next()};
				end
			end
		end
		flush = (rnd(40) == 0);
		rd_arch0 = arch_idx_t'(rnd(ARCH_REGS));
		rd_arch1 = arch_idx_t'(rnd(ARCH_REGS));
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_errors && !hung) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_bad++;
			$display("test %s: %0d mismatches", cur_test, errors - test_errors);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		drive_idle();
		rd_arch0 = '0;
		rd_arch1 = '0;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		hung = 1'b0;
		for (int r = 0; r < ARCH_REGS; r++) begin
			m_val[r] = '0;
			m_cptr[r] = '0;
			m_cnt[r] = 0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		start_test("reset_reads");
		for (int r = 0; r < ARCH_REGS; r++) begin
			rd_arch0 = arch_idx_t'(r);
			rd_arch1 = arch_idx_t'(ARCH_REGS - 1 - r);
			run_cycle();
		end
		finish_test();

		// every spare copy filled so the next request stalls
		start_test("rename_stall");
		for (int n = 0; n < RP - 1; n++)
			wait_grant(REG_A);
		rename_req = 1'b1;
		rename_arch = REG_A;
		run_cycle();
		finish_test();

		start_test("writeback_read");
		post_result(WB_ALU, REG_A, 1);
		post_result(WB_LSU, REG_A, 2);
		post_result(WB_MUL, REG_A, 3);
		run_cycle();
		wait_ready(REG_A);
		finish_test();

		// commit frees copy 0, which is granted next
		start_test("commit_reuse");
		commit_req = 1'b1;
		commit_arch = REG_A;
		wait_grant(REG_A);
		finish_test();

		start_test("flush_restore");
		wait_grant(REG_B);
		flush = 1'b1;
		rename_req = 1'b1;
		rename_arch = REG_C;
		run_cycle();
		for (int r = 0; r < ARCH_REGS; r++) begin
			rd_arch0 = arch_idx_t'(r);
			rd_arch1 = arch_idx_t'(ARCH_REGS - 1 - r);
			run_cycle();
		end
		finish_test();

		start_test("x0_rename");
		rename_req = 1'b1;
		rename_arch = '0;
		rd_arch0 = '0;
		rd_arch1 = '0;
		run_cycle();
		finish_test();

		start_test("random");
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			drive_random();
			run_cycle();
		end
		finish_test();

		$display("tests %0d, tests with errors %0d, mismatches %0d", tests_run, tests_bad,
			errors);
		if (hung || errors != 0) begin
			$display("CHECKS FAILED");
		end else begin
			$display("ALL CHECKS PASSED");
		end
		$finish;
	end

endmodule

//--- rf_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer register-file back end, top level
// rename, write-back, commit and flush enter as plain ports;
// reads return the newest copy and its written flag
// NUM_WB sets the number of write-back ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module rf_core import rf_cfg_pkg::*, wb_pkg::*; #(
	parameter int NUM_WB = NUM_UNITS
) (
	input logic clk,
	input logic reset,
	input logic rename_req,
	input arch_idx_t rename_arch,
	output logic rename_grant,
	output logic rename_stall,
	output phys_idx_u rename_phys,
	input logic [NUM_WB-1:0] wb_valid,
	input phys_idx_u wb_phys [NUM_WB],
	input xdata_t wb_data [NUM_WB],
	input logic commit_req,
	input arch_idx_t commit_arch,
	input logic flush,
	input arch_idx_t rd_arch0,
	input arch_idx_t rd_arch1,
	output xdata_t rd_data0,
	output xdata_t rd_data1,
	output logic rd_ready0,
	output logic rd_ready1
);

	xdata_t rf_q [NUM_PHYS];
	xdata_t rf_next [NUM_PHYS];
	logic [NUM_PHYS-1:0] wb_set;
	phys_state_t state [NUM_PHYS];
	phys_idx_u rd_phys0;
	phys_idx_u rd_phys1;

	// rename to log bookkeeping
	rf_ctl_if i_ctl ();

	rename_table i_rename_table (
		.clk (clk), .reset (reset), .ctl (i_ctl.rename),
		.rename_req (rename_req), .rename_arch (rename_arch),
		.rename_grant (rename_grant), .rename_stall (rename_stall),
		.rename_phys (rename_phys),
		.commit_req (commit_req), .commit_arch (commit_arch), .flush (flush),
		.rd_arch0 (rd_arch0), .rd_arch1 (rd_arch1),
		.rd_phys0 (rd_phys0), .rd_phys1 (rd_phys1)
	);

	wb_log i_wb_log (
		.clk (clk), .reset (reset), .ctl (i_ctl.log),
		.wb_set (wb_set), .state (state)
	);

	write_back #(.NUM_WB (NUM_WB)) i_write_back (
		.rf_q (rf_q), .rf_next (rf_next),
		.wb_valid (wb_valid), .wb_phys (wb_phys), .wb_data (wb_data),
		.wb_set (wb_set)
	);

	phy_regfile i_phy_regfile (
		.clk (clk), .reset (reset),
		.rf_next (rf_next), .rf_q (rf_q),
		.rd_phys0 (rd_phys0), .rd_phys1 (rd_phys1),
		.rd_data0 (rd_data0), .rd_data1 (rd_data1)
	);

	// ready when the newest copy has its result
	assign rd_ready0 = state[rd_phys0.flat].written;
	assign rd_ready1 = state[rd_phys1.flat].written;

endmodule

//--- phy_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register storage with two read ports
// loads the merged next value from write_back every clk;
// x0's copies stay zero since write_back never fills them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module phy_regfile import rf_cfg_pkg::*; (
	input logic clk,
	input logic reset,
	input xdata_t rf_next [NUM_PHYS],
	output xdata_t rf_q [NUM_PHYS],
	input phys_idx_u rd_phys0,
	input phys_idx_u rd_phys1,
	output xdata_t rd_data0,
	output xdata_t rd_data1
);

	// all words cleared so copy 0 of each register reads zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int p = 0; p < NUM_PHYS; p++) begin
				rf_q[p] <= '0;
			end
		end else begin
			for (int p = 0; p < NUM_PHYS; p++) begin
				rf_q[p] <= rf_next[p];
			end
		end
	end

	// combinational reads by flat index
	assign rd_data0 = rf_q[rd_phys0.flat];
	assign rd_data1 = rf_q[rd_phys1.flat];

endmodule

//--- rename_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename and commit pointers per architectural register
// grants a new copy when the next one is free, stalls
// otherwise, retires on commit and rewinds on flush
// also maps the two read registers to their latest copy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module rename_table import rf_cfg_pkg::*; (
	input logic clk,
	input logic reset,
	rf_ctl_if.rename ctl,
	input logic rename_req,
	input arch_idx_t rename_arch,
	output logic rename_grant,
	output logic rename_stall,
	output phys_idx_u rename_phys,
	input logic commit_req,
	input arch_idx_t commit_arch,
	input logic flush,
	input arch_idx_t rd_arch0,
	input arch_idx_t rd_arch1,
	output phys_idx_u rd_phys0,
	output phys_idx_u rd_phys1
);

	// wrapping pointers, one pair per arch register
	copy_idx_t rename_ptr [ARCH_REGS];
	copy_idx_t commit_ptr [ARCH_REGS];
	copy_idx_t commit_nxt [ARCH_REGS];

	// candidate copy wraps modulo RP
	always_comb begin
		rename_phys.f.arch = rename_arch;
		rename_phys.f.copy = rename_ptr[rename_arch] + copy_idx_t'(1);
	end

	// next copy must be free and flush wins over rename
	assign rename_grant = rename_req && (rename_arch != '0) && !flush
		&& !ctl.busy[rename_phys.flat];
	assign rename_stall = rename_req && (rename_arch != '0) && !rename_grant;

	for (genvar a = 0; a < ARCH_REGS; a++) begin : g_commit
		// commit pointer after this cycle's commit
		assign commit_nxt[a] = commit_ptr[a]
			+ copy_idx_t'(commit_req && (commit_arch == arch_idx_t'(a)));
		// protect the copy that stays committed, so a
		// commit in the flush cycle is kept as well
		for (genvar c = 0; c < RP; c++) begin : g_keep
			assign ctl.keep_mask[a * RP + c] = (commit_nxt[a] == copy_idx_t'(c));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int a = 0; a < ARCH_REGS; a++) begin
				rename_ptr[a] <= '0;
				commit_ptr[a] <= '0;
			end
		end else begin
			for (int a = 0; a < ARCH_REGS; a++) begin
				commit_ptr[a] <= commit_nxt[a];
				// rewind to committed state
				if (flush) begin
					rename_ptr[a] <= commit_nxt[a];
				end else if (rename_grant && (rename_arch == arch_idx_t'(a))) begin
					rename_ptr[a] <= rename_phys.f.copy;
				end
			end
		end
	end

	// bookkeeping to the log
	assign ctl.alloc = rename_grant;
	assign ctl.alloc_phys = rename_phys;
	assign ctl.flush = flush;

	// old committed copy is released
	assign ctl.retire = commit_req;
	always_comb begin
		ctl.retire_phys.f.arch = commit_arch;
		ctl.retire_phys.f.copy = commit_ptr[commit_arch];
	end

	// reads see the newest renamed copy
	always_comb begin
		rd_phys0.f.arch = rd_arch0;
		rd_phys0.f.copy = rename_ptr[rd_arch0];
		rd_phys1.f.arch = rd_arch1;
		rd_phys1.f.copy = rename_ptr[rd_arch1];
	end

	// commit must trail renaming
	a_commit_order: assert property (@(posedge clk) disable iff (reset)
		commit_req |-> (commit_ptr[commit_arch] != rename_ptr[commit_arch]));

	// x0 has nothing to commit
	a_commit_x0: assert property (@(posedge clk) disable iff (reset)
		commit_req |-> (commit_arch != '0));

endmodule

//--- wb_log.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// busy / written log of every physical register
// driven by rename_table through rf_ctl_if and by the
// written mask from write_back; busy goes back to renaming
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module wb_log import rf_cfg_pkg::*, wb_pkg::*; (
	input logic clk,
	input logic reset,
	rf_ctl_if.log ctl,
	input logic [NUM_PHYS-1:0] wb_set,
	output phys_state_t state [NUM_PHYS]
);

	for (genvar a = 0; a < ARCH_REGS; a++) begin : g_arch
		for (genvar c = 0; c < RP; c++) begin : g_copy
			localparam int P = a * RP + c;
			// copy 0 holds the architectural value out of reset
			localparam logic INIT = (c == 0);

			logic alloc_hit;
			logic retire_hit;

			// decode requests by arch / copy fields
			assign alloc_hit = ctl.alloc && (ctl.alloc_phys.f.arch == arch_idx_t'(a))
				&& (ctl.alloc_phys.f.copy == copy_idx_t'(c));
			assign retire_hit = ctl.retire && (ctl.retire_phys.f.arch == arch_idx_t'(a))
				&& (ctl.retire_phys.f.copy == copy_idx_t'(c));

			always_ff @(posedge clk) begin
				if (reset) begin
					state[P].busy <= INIT;
					state[P].written <= INIT;
				end else begin
					// flush drops every copy not committed
					if (ctl.flush && !ctl.keep_mask[P]) begin
						state[P].busy <= 1'b0;
					end else if (retire_hit) begin
						state[P].busy <= 1'b0;
					end else if (alloc_hit) begin
						state[P].busy <= 1'b1;
					end
					// new owner waits for its result
					if (alloc_hit) begin
						state[P].written <= 1'b0;
					end else if (wb_set[P]) begin
						state[P].written <= 1'b1;
					end
				end
			end

			assign ctl.busy[P] = state[P].busy;
		end
	end

	// results only land in allocated copies
	a_wb_busy: assert property (@(posedge clk) disable iff (reset)
		(wb_set & ~ctl.busy) == '0);

	// released copy always carried a result
	a_retire_written: assert property (@(posedge clk) disable iff (reset)
		ctl.retire |-> state[ctl.retire_phys.flat].written);

endmodule

//--- write_back.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back merge into the physical register file
// builds the next value of every word from NUM_WB result
// ports and flags the words written this cycle
// x0's copies are forced to zero and never flagged
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module write_back import rf_cfg_pkg::*, wb_pkg::*; #(
	parameter int NUM_WB = NUM_UNITS
) (
	input xdata_t rf_q [NUM_PHYS],
	output xdata_t rf_next [NUM_PHYS],
	input logic [NUM_WB-1:0] wb_valid,
	input phys_idx_u wb_phys [NUM_WB],
	input xdata_t wb_data [NUM_WB],
	output logic [NUM_PHYS-1:0] wb_set
);

	for (genvar p = 0; p < NUM_PHYS; p++) begin : g_phys
		if (p < RP) begin : g_x0
			// hardwired zero register
			assign rf_next[p] = '0;
			assign wb_set[p] = 1'b0;
		end else begin : g_reg
			logic [NUM_WB-1:0] hit;
			xdata_t merged;

			// port i addresses this word
			for (genvar i = 0; i < NUM_WB; i++) begin : g_hit
				assign hit[i] = wb_valid[i] && (wb_phys[i].flat == PHYS_W'(p));
			end

			// and-or mux over the ports with at most one hit
			always_comb begin
				merged = '0;
				for (int i = 0; i < NUM_WB; i++) begin
					merged |= {XLEN{hit[i]}} & wb_data[i];
				end
			end

			// old value held when nobody writes
			assign rf_next[p] = (|hit) ? merged : rf_q[p];
			assign wb_set[p] = |hit;
		end
	end

	// one writer per word and never into x0
	always_comb begin
		for (int i = 0; i < NUM_WB; i++) begin
			if (wb_valid[i]) begin
				assert (wb_phys[i].f.arch != '0)
					else $error("wb port %0d writes x0", i);
			end
			for (int j = i + 1; j < NUM_WB; j++) begin
				if (wb_valid[i] && wb_valid[j]) begin
					assert (wb_phys[i] != wb_phys[j])
						else $error("wb ports %0d and %0d collide", i, j);
				end
			end
		end
	end

endmodule

//--- rf_ctl_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bookkeeping path between rename_table and wb_log
// allocation, retirement and flush requests go one way,
// the busy vector comes back; all pulses act at the next clk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface rf_ctl_if import rf_cfg_pkg::*; ();

	// copy claimed by a granted rename
	logic alloc;
	phys_idx_u alloc_phys;

	// previous committed copy released on commit
	logic retire;
	phys_idx_u retire_phys;

	// squash of everything past the committed copies
	logic flush;
	logic [NUM_PHYS-1:0] keep_mask;

	// from the log
	logic [NUM_PHYS-1:0] busy;

	modport rename (output alloc, alloc_phys, retire, retire_phys, flush, keep_mask,
		input busy);

	modport log (input alloc, alloc_phys, retire, retire_phys, flush, keep_mask,
		output busy);

	// observation only
	modport top (input alloc, alloc_phys, retire, retire_phys, flush, keep_mask, busy);

endinterface

//--- wb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back side definitions
// execution units that own a write-back port and the
// busy / written state kept per physical register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wb_pkg;

	// one write-back port per unit, in port order
	typedef enum logic [2:0] {
		WB_ALU,
		WB_BRU,
		WB_LSU,
		WB_CSR,
		WB_MUL
	} wb_unit_e;

	// number of units follows the enumeration
	localparam int NUM_UNITS = int'(WB_MUL) + 1;

	// busy while the copy is allocated and not yet released
	// written once its result has arrived
	typedef struct packed {
		logic busy;
		logic written;
	} phys_state_t;

endpackage

//--- rf_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register-file geometry for the renamed integer back end
// each architectural register owns RP physical copies
// physical index = arch * RP + copy, seen flat or as fields
// imported by every RTL block and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rf_cfg_pkg;

	// data width
	localparam int XLEN = 64;

	// architectural side
	localparam int ARCH_REGS = 32;
	localparam int ARCH_W = 5;

	// power-of-two count of copies per arch register
	localparam int RP = 4;
	localparam int COPY_W = 2;

	// physical side
	localparam int PHYS_W = ARCH_W + COPY_W;
	localparam int NUM_PHYS = ARCH_REGS * RP;

	typedef logic [XLEN-1:0] xdata_t;
	typedef logic [ARCH_W-1:0] arch_idx_t;
	typedef logic [COPY_W-1:0] copy_idx_t;

	// arch index in the upper bits and copy in the lower bits
	typedef struct packed {
		arch_idx_t arch;
		copy_idx_t copy;
	} phys_fields_t;

	// flat view for word select and field view for bookkeeping
	typedef union packed {
		logic [PHYS_W-1:0] flat;
		phys_fields_t f;
	} phys_idx_u;

endpackage
